// ==== include/dds_sine_lut.svh ====
/*
 * quarter-wave sine lookup
 * 8-bit phase in, signed 16-bit sine out, other quadrants by mirror and negate
 */
`ifndef DDS_SINE_LUT_SVH
`define DDS_SINE_LUT_SVH

// first quadrant, sampled at half-step offsets so the mirror is exact
localparam logic [15:0] dds_quarter_sine [0:63] = '{
  402,   1206,  2009,  2811,  3612,  4410,  5205,  5998,
  6786,  7571,  8351,  9126,  9896,  10659, 11417, 12167,
  12910, 13645, 14372, 15091, 15800, 16500, 17189, 17869,
  18537, 19195, 19841, 20475, 21097, 21706, 22301, 22884,
  23453, 24007, 24547, 25072, 25583, 26077, 26556, 27020,
  27466, 27897, 28310, 28706, 29085, 29447, 29791, 30117,
  30425, 30714, 30985, 31237, 31471, 31685, 31881, 32057,
  32214, 32351, 32469, 32568, 32646, 32705, 32745, 32765
};

// phase[7] picks the sign, phase[6] the falling half of each half wave
function automatic logic signed [15:0] dds_sine(input logic [7:0] phase);
  logic [5:0]  idx;
  logic [15:0] mag;

  idx = phase[6] ? ~phase[5:0] : phase[5:0];
  mag = dds_quarter_sine[idx];
  if (phase[7]) begin
    dds_sine = -$signed(mag);
  end else begin
    dds_sine = $signed(mag);
  end
endfunction

`endif

// ==== source/dac_chan_pkg.sv ====
/*
 * dac channel package
 * sample, phase, register bus and source select types, register map
 */
`default_nettype none

package dac_chan_pkg;

  // data path widths
  typedef logic [15:0] dac_sample_t;
  typedef logic [63:0] dac_beat_t;
  typedef logic [15:0] dds_phase_t;
  typedef logic [15:0] dds_scale_t;

  // register bus
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // output source select, unlisted codes fall back to dds
  typedef enum logic [3:0] {
    sel_dds           = 4'h0,
    sel_pattern_frame = 4'h1,
    sel_dma           = 4'h2,
    sel_pattern       = 4'ha
  } dac_sel_t;

  // register map
  localparam reg_addr_t addr_sel     = 8'h00;
  localparam reg_addr_t addr_init_1  = 8'h01;
  localparam reg_addr_t addr_incr_1  = 8'h02;
  localparam reg_addr_t addr_scale_1 = 8'h03;
  localparam reg_addr_t addr_init_2  = 8'h04;
  localparam reg_addr_t addr_incr_2  = 8'h05;
  localparam reg_addr_t addr_scale_2 = 8'h06;
  localparam reg_addr_t addr_pat_1   = 8'h07;
  localparam reg_addr_t addr_pat_2   = 8'h08;
  // read only
  localparam reg_addr_t addr_chan_id = 8'h0f;

endpackage

`default_nettype wire

// ==== source/dac_chan_regs.sv ====
/*
 * dac channel register file
 * strobed write and read with a one-cycle acknowledge, holds tone and pattern settings
 */
`timescale 1ns/1ps
`default_nettype none

module dac_chan_regs #(
  parameter dac_chan_pkg::reg_data_t CHANNEL_ID = 32'h0
) (
  input  wire                       dac_div_clk,
  input  wire                       reset,
  input  wire                       wr_strobe,
  input  wire dac_chan_pkg::reg_addr_t wr_addr,
  input  wire dac_chan_pkg::reg_data_t wr_data,
  input  wire                       rd_strobe,
  input  wire dac_chan_pkg::reg_addr_t rd_addr,
  output logic                      wr_ack,
  output logic                      rd_ack,
  output dac_chan_pkg::reg_data_t   rd_data,
  output dac_chan_pkg::dac_sel_t    sel,
  output dac_chan_pkg::dds_phase_t  init_1,
  output dac_chan_pkg::dds_phase_t  incr_1,
  output dac_chan_pkg::dds_phase_t  init_2,
  output dac_chan_pkg::dds_phase_t  incr_2,
  output dac_chan_pkg::dds_scale_t  scale_1,
  output dac_chan_pkg::dds_scale_t  scale_2,
  output dac_chan_pkg::dac_sample_t pat_1,
  output dac_chan_pkg::dac_sample_t pat_2
);

  dac_chan_pkg::reg_data_t rd_value;

  // ************************************************************************
  // write decode

  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      wr_ack  <= 1'b0;
      sel     <= dac_chan_pkg::sel_dds;
      init_1  <= '0;
      incr_1  <= '0;
      scale_1 <= '0;
      init_2  <= '0;
      incr_2  <= '0;
      scale_2 <= '0;
      pat_1   <= '0;
      pat_2   <= '0;
    end else begin
      wr_ack <= wr_strobe;
      if (wr_strobe) begin
        case (wr_addr)
          dac_chan_pkg::addr_sel:     sel     <= dac_chan_pkg::dac_sel_t'(wr_data[3:0]);
          dac_chan_pkg::addr_init_1:  init_1  <= wr_data[15:0];
          dac_chan_pkg::addr_incr_1:  incr_1  <= wr_data[15:0];
          dac_chan_pkg::addr_scale_1: scale_1 <= wr_data[15:0];
          dac_chan_pkg::addr_init_2:  init_2  <= wr_data[15:0];
          dac_chan_pkg::addr_incr_2:  incr_2  <= wr_data[15:0];
          dac_chan_pkg::addr_scale_2: scale_2 <= wr_data[15:0];
          dac_chan_pkg::addr_pat_1:   pat_1   <= wr_data[15:0];
          dac_chan_pkg::addr_pat_2:   pat_2   <= wr_data[15:0];
          // chan id and unmapped addresses take the ack only
          default: ;
        endcase
      end
    end
  end

  // ************************************************************************
  // read back

  always_comb begin
    rd_value = '0;
    case (rd_addr)
      dac_chan_pkg::addr_sel:     rd_value = {28'd0, sel};
      dac_chan_pkg::addr_init_1:  rd_value = {16'd0, init_1};
      dac_chan_pkg::addr_incr_1:  rd_value = {16'd0, incr_1};
      dac_chan_pkg::addr_scale_1: rd_value = {16'd0, scale_1};
      dac_chan_pkg::addr_init_2:  rd_value = {16'd0, init_2};
      dac_chan_pkg::addr_incr_2:  rd_value = {16'd0, incr_2};
      dac_chan_pkg::addr_scale_2: rd_value = {16'd0, scale_2};
      dac_chan_pkg::addr_pat_1:   rd_value = {16'd0, pat_1};
      dac_chan_pkg::addr_pat_2:   rd_value = {16'd0, pat_2};
      dac_chan_pkg::addr_chan_id: rd_value = CHANNEL_ID;
      default:                    rd_value = '0;
    endcase
  end

  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      rd_ack  <= 1'b0;
      rd_data <= '0;
    end else begin
      rd_ack  <= rd_strobe;
      rd_data <= rd_strobe ? rd_value : '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/dds_phase_accum.sv ====
/*
 * dds phase accumulators
 * four interleaved lanes per tone, two tones, reloaded and staggered on sync
 */
`timescale 1ns/1ps
`default_nettype none

module dds_phase_accum (
  input  wire                      dac_div_clk,
  input  wire                      reset,
  input  wire                      data_sync,
  input  wire dac_chan_pkg::dds_phase_t init_1,
  input  wire dac_chan_pkg::dds_phase_t incr_1,
  input  wire dac_chan_pkg::dds_phase_t init_2,
  input  wire dac_chan_pkg::dds_phase_t incr_2,
  output dac_chan_pkg::dds_phase_t phase_1_lane0,
  output dac_chan_pkg::dds_phase_t phase_1_lane1,
  output dac_chan_pkg::dds_phase_t phase_1_lane2,
  output dac_chan_pkg::dds_phase_t phase_1_lane3,
  output dac_chan_pkg::dds_phase_t phase_2_lane0,
  output dac_chan_pkg::dds_phase_t phase_2_lane1,
  output dac_chan_pkg::dds_phase_t phase_2_lane2,
  output dac_chan_pkg::dds_phase_t phase_2_lane3
);

  // index 0 is tone 1, index 1 is tone 2
  dac_chan_pkg::dds_phase_t init  [2];
  dac_chan_pkg::dds_phase_t incr  [2];
  dac_chan_pkg::dds_phase_t step  [2];
  dac_chan_pkg::dds_phase_t phase [2][4];

  assign init[0] = init_1;
  assign init[1] = init_2;
  assign incr[0] = incr_1;
  assign incr[1] = incr_2;

  // sync: lane k starts k increments in, step covers all four lanes
  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      for (int t = 0; t < 2; t++) begin
        step[t] <= '0;
        for (int k = 0; k < 4; k++) begin
          phase[t][k] <= '0;
        end
      end
    end else if (data_sync) begin
      for (int t = 0; t < 2; t++) begin
        step[t] <= {incr[t][13:0], 2'b00};
        for (int k = 0; k < 4; k++) begin
          phase[t][k] <= init[t] + dac_chan_pkg::dds_phase_t'(incr[t] * k);
        end
      end
    end else begin
      for (int t = 0; t < 2; t++) begin
        for (int k = 0; k < 4; k++) begin
          phase[t][k] <= phase[t][k] + step[t];
        end
      end
    end
  end

  assign phase_1_lane0 = phase[0][0];
  assign phase_1_lane1 = phase[0][1];
  assign phase_1_lane2 = phase[0][2];
  assign phase_1_lane3 = phase[0][3];
  assign phase_2_lane0 = phase[1][0];
  assign phase_2_lane1 = phase[1][1];
  assign phase_2_lane2 = phase[1][2];
  assign phase_2_lane3 = phase[1][3];

endmodule

`default_nettype wire

// ==== source/dds_tone_gen.sv ====
/*
 * dds tone generator
 * sine lookup, amplitude scaling and two-tone sum for four lanes in parallel
 */
`timescale 1ns/1ps
`default_nettype none

module dds_tone_gen #(
  parameter int DATAPATH_DISABLE = 0
) (
  input  wire                      dac_div_clk,
  input  wire                      reset,
  input  wire                      dds_format,
  input  wire dac_chan_pkg::dds_phase_t phase_1_lane0,
  input  wire dac_chan_pkg::dds_phase_t phase_1_lane1,
  input  wire dac_chan_pkg::dds_phase_t phase_1_lane2,
  input  wire dac_chan_pkg::dds_phase_t phase_1_lane3,
  input  wire dac_chan_pkg::dds_phase_t phase_2_lane0,
  input  wire dac_chan_pkg::dds_phase_t phase_2_lane1,
  input  wire dac_chan_pkg::dds_phase_t phase_2_lane2,
  input  wire dac_chan_pkg::dds_phase_t phase_2_lane3,
  input  wire dac_chan_pkg::dds_scale_t scale_1,
  input  wire dac_chan_pkg::dds_scale_t scale_2,
  output dac_chan_pkg::dac_beat_t  dds_beat
);

  `include "dds_sine_lut.svh"

  dac_chan_pkg::dds_phase_t  phase_1  [4];
  dac_chan_pkg::dds_phase_t  phase_2  [4];
  logic signed [15:0]        sine_1   [4];
  logic signed [15:0]        sine_2   [4];
  dac_chan_pkg::dac_sample_t lane_sum [4];

  // amplitude 32768 is unity, keep bits [30:15] of the product
  function automatic dac_chan_pkg::dac_sample_t dds_scaled(
    input logic signed [15:0]      sine,
    input dac_chan_pkg::dds_scale_t scale
  );
    logic signed [32:0] prod;

    prod = sine * $signed({1'b0, scale});
    dds_scaled = prod[30:15];
  endfunction

  assign phase_1[0] = phase_1_lane0;
  assign phase_1[1] = phase_1_lane1;
  assign phase_1[2] = phase_1_lane2;
  assign phase_1[3] = phase_1_lane3;
  assign phase_2[0] = phase_2_lane0;
  assign phase_2[1] = phase_2_lane1;
  assign phase_2[2] = phase_2_lane2;
  assign phase_2[3] = phase_2_lane3;

  // stage 1: table lookup on the top phase byte
  always_ff @(posedge dac_div_clk) begin
    for (int k = 0; k < 4; k++) begin
      if (reset) begin
        sine_1[k] <= '0;
        sine_2[k] <= '0;
      end else begin
        sine_1[k] <= dds_sine(phase_1[k][15:8]);
        sine_2[k] <= dds_sine(phase_2[k][15:8]);
      end
    end
  end

  // tone sum wraps at 16 bits
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      lane_sum[k] = dds_scaled(sine_1[k], scale_1) + dds_scaled(sine_2[k], scale_2);
    end
  end

  // stage 2: offset binary flips the sign bit
  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      dds_beat <= '0;
    end else if (DATAPATH_DISABLE == 1) begin
      dds_beat <= '0;
    end else begin
      for (int k = 0; k < 4; k++) begin
        dds_beat[16*k +: 16] <= {lane_sum[k][15] ^ dds_format, lane_sum[k][14:0]};
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_data_mux.sv ====
/*
 * dac output select
 * registers dds, pattern or dma data into the beat, drives frame and dma enable
 */
`timescale 1ns/1ps
`default_nettype none

module dac_data_mux (
  input  wire                       dac_div_clk,
  input  wire                       reset,
  input  wire dac_chan_pkg::dac_sel_t    sel,
  input  wire                       data_sync,
  input  wire dac_chan_pkg::dac_beat_t   dds_beat,
  input  wire dac_chan_pkg::dac_beat_t   dma_data,
  input  wire dac_chan_pkg::dac_sample_t pat_1,
  input  wire dac_chan_pkg::dac_sample_t pat_2,
  output dac_chan_pkg::dac_beat_t   dac_data,
  output logic [3:0]                dac_frame,
  output logic                      dac_enable
);

  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      dac_data   <= '0;
      dac_frame  <= 4'b0000;
      dac_enable <= 1'b0;
    end else begin
      // dma only pulls data while it is the source
      dac_enable <= (sel == dac_chan_pkg::sel_dma);
      case (sel)
        dac_chan_pkg::sel_dma: dac_data <= dma_data;
        dac_chan_pkg::sel_pattern,
        dac_chan_pkg::sel_pattern_frame: dac_data <= {pat_2, pat_1, pat_2, pat_1};
        // dds blanked while the phases reload
        default: dac_data <= data_sync ? '0 : dds_beat;
      endcase
      if (sel == dac_chan_pkg::sel_pattern_frame) begin
        dac_frame <= 4'b0101;
      end else begin
        dac_frame <= {3'b000, data_sync};
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_channel_top.sv ====
/*
 * dac transmit channel
 * register file, dds phase and tone stages, output select
 */
`timescale 1ns/1ps
`default_nettype none

module dac_channel_top #(
  parameter dac_chan_pkg::reg_data_t CHANNEL_ID = 32'h0,
  parameter int DATAPATH_DISABLE = 0
) (
  input  wire                       dac_div_clk,
  input  wire                       reset,
  // register bus
  input  wire                       wr_strobe,
  input  wire dac_chan_pkg::reg_addr_t wr_addr,
  input  wire dac_chan_pkg::reg_data_t wr_data,
  input  wire                       rd_strobe,
  input  wire dac_chan_pkg::reg_addr_t rd_addr,
  output logic                      wr_ack,
  output dac_chan_pkg::reg_data_t   rd_data,
  output logic                      rd_ack,
  // control
  input  wire                       data_sync,
  input  wire                       dds_format,
  // data
  input  wire dac_chan_pkg::dac_beat_t dma_data,
  output dac_chan_pkg::dac_beat_t   dac_data,
  output logic [3:0]                dac_frame,
  output logic                      dac_enable
);

  dac_chan_pkg::dac_sel_t    sel;
  dac_chan_pkg::dds_phase_t  init_1;
  dac_chan_pkg::dds_phase_t  incr_1;
  dac_chan_pkg::dds_phase_t  init_2;
  dac_chan_pkg::dds_phase_t  incr_2;
  dac_chan_pkg::dds_scale_t  scale_1;
  dac_chan_pkg::dds_scale_t  scale_2;
  dac_chan_pkg::dac_sample_t pat_1;
  dac_chan_pkg::dac_sample_t pat_2;
  dac_chan_pkg::dds_phase_t  ph_1_l0, ph_1_l1, ph_1_l2, ph_1_l3;
  dac_chan_pkg::dds_phase_t  ph_2_l0, ph_2_l1, ph_2_l2, ph_2_l3;
  dac_chan_pkg::dac_beat_t   dds_beat;

  // ************************************************************************
  // settings

  dac_chan_regs #(.CHANNEL_ID(CHANNEL_ID)) regs_i (
    .dac_div_clk (dac_div_clk), .reset (reset),
    .wr_strobe (wr_strobe), .wr_addr (wr_addr), .wr_data (wr_data),
    .rd_strobe (rd_strobe), .rd_addr (rd_addr),
    .wr_ack (wr_ack), .rd_ack (rd_ack), .rd_data (rd_data),
    .sel (sel), .init_1 (init_1), .incr_1 (incr_1), .init_2 (init_2), .incr_2 (incr_2),
    .scale_1 (scale_1), .scale_2 (scale_2), .pat_1 (pat_1), .pat_2 (pat_2)
  );

  // ************************************************************************
  // dds pipeline and output

  dds_phase_accum accum_i (
    .dac_div_clk (dac_div_clk), .reset (reset), .data_sync (data_sync),
    .init_1 (init_1), .incr_1 (incr_1), .init_2 (init_2), .incr_2 (incr_2),
    .phase_1_lane0 (ph_1_l0), .phase_1_lane1 (ph_1_l1),
    .phase_1_lane2 (ph_1_l2), .phase_1_lane3 (ph_1_l3),
    .phase_2_lane0 (ph_2_l0), .phase_2_lane1 (ph_2_l1),
    .phase_2_lane2 (ph_2_l2), .phase_2_lane3 (ph_2_l3)
  );

  dds_tone_gen #(.DATAPATH_DISABLE(DATAPATH_DISABLE)) tone_i (
    .dac_div_clk (dac_div_clk), .reset (reset), .dds_format (dds_format),
    .phase_1_lane0 (ph_1_l0), .phase_1_lane1 (ph_1_l1),
    .phase_1_lane2 (ph_1_l2), .phase_1_lane3 (ph_1_l3),
    .phase_2_lane0 (ph_2_l0), .phase_2_lane1 (ph_2_l1),
    .phase_2_lane2 (ph_2_l2), .phase_2_lane3 (ph_2_l3),
    .scale_1 (scale_1), .scale_2 (scale_2), .dds_beat (dds_beat)
  );

  dac_data_mux mux_i (
    .dac_div_clk (dac_div_clk), .reset (reset), .sel (sel), .data_sync (data_sync),
    .dds_beat (dds_beat), .dma_data (dma_data), .pat_1 (pat_1), .pat_2 (pat_2),
    .dac_data (dac_data), .dac_frame (dac_frame), .dac_enable (dac_enable)
  );

endmodule

`default_nettype wire

// ==== bench/dac_channel_model.sv ====
/*
 * dac channel reference model
 * tone settings, phase state and beat prediction for the testbench
 */
`default_nettype none

package dac_channel_model;

  // the tone generator has already pulled the table in and set the guard
  `undef DDS_SINE_LUT_SVH
  `include "dds_sine_lut.svh"

  // tone settings, index 0 is tone 1
  logic [15:0] tone_init  [2];
  logic [15:0] tone_incr  [2];
  logic [15:0] tone_scale [2];
  logic [15:0] tone_step  [2];
  logic [15:0] tone_phase [2][4];

  function automatic void set_tone(input int t, input logic [15:0] init,
                                   input logic [15:0] incr, input logic [15:0] scale);
    tone_init[t]  = init;
    tone_incr[t]  = incr;
    tone_scale[t] = scale;
  endfunction

  // one clock edge of the accumulators
  function automatic void advance_phases(input logic sync);
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < 4; k++) begin
        if (sync) begin
          tone_phase[t][k] = 16'(tone_init[t] + k * tone_incr[t]);
        end else begin
          tone_phase[t][k] = tone_phase[t][k] + tone_step[t];
        end
      end
      if (sync) begin
        tone_step[t] = 16'(tone_incr[t] * 4);
      end
    end
  endfunction

  // beat that the current phases turn into, two stages later
  function automatic logic [63:0] predict_dds(input logic fmt);
    logic [63:0]        beat;
    logic [15:0]        sample;
    logic signed [15:0] sine;
    longint             scaled [2];

    beat = '0;
    for (int k = 0; k < 4; k++) begin
      for (int t = 0; t < 2; t++) begin
        sine = dds_sine(tone_phase[t][k][15:8]);
        scaled[t] = (longint'(sine) * longint'(tone_scale[t])) >>> 15;
      end
      sample = 16'(scaled[0]) + 16'(scaled[1]);
      if (fmt) begin
        sample = sample ^ 16'h8000;
      end
      beat[16*k +: 16] = sample;
    end
    return beat;
  endfunction

  function automatic logic [63:0] predict_mux(input dac_chan_pkg::dac_sel_t sel,
                                              input logic sync, input logic [63:0] dds,
                                              input logic [63:0] dma,
                                              input logic [15:0] pat_1,
                                              input logic [15:0] pat_2);
    case (sel)
      dac_chan_pkg::sel_dma:           return dma;
      dac_chan_pkg::sel_pattern:       return {pat_2, pat_1, pat_2, pat_1};
      dac_chan_pkg::sel_pattern_frame: return {pat_2, pat_1, pat_2, pat_1};
      default:                         return sync ? 64'd0 : dds;
    endcase
  endfunction

  function automatic logic [3:0] predict_frame(input dac_chan_pkg::dac_sel_t sel,
                                               input logic sync);
    return (sel == dac_chan_pkg::sel_pattern_frame) ? 4'b0101 : {3'b000, sync};
  endfunction

  function automatic logic predict_enable(input dac_chan_pkg::dac_sel_t sel);
    return sel == dac_chan_pkg::sel_dma;
  endfunction

endpackage

`default_nettype wire

// ==== bench/dac_channel_tb.sv ====
/*
 * dac channel testbench
 * reset, register, dma, pattern and dds checks against the reference model
 */
`timescale 1ns/1ps
`default_nettype none

module dac_channel_tb;

  localparam int CLK_PERIOD = 10;
  localparam dac_chan_pkg::reg_data_t CHANNEL_ID = 32'h0000_0003;
  localparam int MUX_CYCLES = 64;
  localparam int DDS_CYCLES = 200;
  // reset, registers, dma, pattern, two dds runs
  localparam int TEST_CYCLES = 12 + 21 * 3 + (3 + MUX_CYCLES) + (4 * 3 + 2 * MUX_CYCLES)
                             + 2 * (7 * 3 + 4 + DDS_CYCLES);
  localparam dac_chan_pkg::reg_addr_t REG_ADDRS [10] = '{
    dac_chan_pkg::addr_sel, dac_chan_pkg::addr_init_1, dac_chan_pkg::addr_incr_1,
    dac_chan_pkg::addr_scale_1, dac_chan_pkg::addr_init_2, dac_chan_pkg::addr_incr_2,
    dac_chan_pkg::addr_scale_2, dac_chan_pkg::addr_pat_1, dac_chan_pkg::addr_pat_2,
    dac_chan_pkg::addr_chan_id
  };

  logic                      dac_div_clk = 1'b0;
  logic                      reset;
  logic                      wr_strobe;
  dac_chan_pkg::reg_addr_t   wr_addr;
  dac_chan_pkg::reg_data_t   wr_data;
  logic                      rd_strobe;
  dac_chan_pkg::reg_addr_t   rd_addr;
  logic                      wr_ack;
  logic                      rd_ack;
  dac_chan_pkg::reg_data_t   rd_data;
  logic                      data_sync;
  logic                      dds_format;
  dac_chan_pkg::dac_beat_t   dma_data;
  dac_chan_pkg::dac_beat_t   dac_data;
  logic [3:0]                dac_frame;
  logic                      dac_enable;
  logic [31:0]               lfsr_state = 32'he041_5fd4;
  dac_chan_pkg::reg_data_t   written [10];
  logic [15:0]               pat_a;
  logic [15:0]               pat_b;
  int                        errors = 0;
  int                        start_errors = 0;
  int                        tests = 0;
  int                        failed_tests = 0;

  dac_channel_top #(.CHANNEL_ID(CHANNEL_ID), .DATAPATH_DISABLE(0)) dut_i (
    .dac_div_clk (dac_div_clk), .reset (reset),
    .wr_strobe (wr_strobe), .wr_addr (wr_addr), .wr_data (wr_data),
    .rd_strobe (rd_strobe), .rd_addr (rd_addr),
    .wr_ack (wr_ack), .rd_data (rd_data), .rd_ack (rd_ack),
    .data_sync (data_sync), .dds_format (dds_format),
    .dma_data (dma_data), .dac_data (dac_data), .dac_frame (dac_frame),
    .dac_enable (dac_enable)
  );

  always #(CLK_PERIOD / 2) dac_div_clk = ~dac_div_clk;

  // ************************************************************************
  // helpers

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] random_bits(input int count);
    logic [63:0] value;
    logic        out_bit;

    value = '0;
    for (int i = 0; i < count; i++) begin
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      value = {value[62:0], out_bit};
    end
    return value;
  endfunction

  function automatic void report_mismatch(input string name, input logic [63:0] expected,
                                          input logic [63:0] actual);
    errors++;
    $display("[FAIL] time %0d ns: %s expected %h, got %h", $time, name, expected, actual);
  endfunction

  function automatic dac_chan_pkg::reg_data_t expected_read(input int idx);
    case (REG_ADDRS[idx])
      dac_chan_pkg::addr_sel:     return written[idx] & 32'h0000_000f;
      dac_chan_pkg::addr_chan_id: return CHANNEL_ID;
      default:                    return written[idx] & 32'h0000_ffff;
    endcase
  endfunction

  task automatic finish_test(input string name);
    tests++;
    if (errors == start_errors) begin
      $display("test %-22s ok", name);
    end else begin
      failed_tests++;
      $display("test %-22s failed with %0d errors", name, errors - start_errors);
    end
  endtask

  // strobe for one cycle, ack must follow for exactly one cycle
  task automatic write_reg(input dac_chan_pkg::reg_addr_t addr,
                           input dac_chan_pkg::reg_data_t data);
    @(posedge dac_div_clk);
    wr_strobe <= 1'b1;
    wr_addr   <= addr;
    wr_data   <= data;
    @(posedge dac_div_clk);
    wr_strobe <= 1'b0;
    @(negedge dac_div_clk);
    if (wr_ack !== 1'b1) report_mismatch("wr_ack", 64'd1, 64'(wr_ack));
    @(negedge dac_div_clk);
    if (wr_ack !== 1'b0) report_mismatch("wr_ack", 64'd0, 64'(wr_ack));
  endtask

  task automatic read_check(input dac_chan_pkg::reg_addr_t addr,
                            input dac_chan_pkg::reg_data_t expected);
    @(posedge dac_div_clk);
    rd_strobe <= 1'b1;
    rd_addr   <= addr;
    @(posedge dac_div_clk);
    rd_strobe <= 1'b0;
    @(negedge dac_div_clk);
    if (rd_ack !== 1'b1) report_mismatch("rd_ack", 64'd1, 64'(rd_ack));
    if (rd_data !== expected) report_mismatch("rd_data", 64'(expected), 64'(rd_data));
    @(negedge dac_div_clk);
    if (rd_ack !== 1'b0) report_mismatch("rd_ack", 64'd0, 64'(rd_ack));
  endtask

  // random dma beats and sync bits through a non-dds source
  task automatic mux_cycles(input dac_chan_pkg::dac_sel_t sel_now, input logic [15:0] p1,
                            input logic [15:0] p2, input int count);
    dac_chan_pkg::dac_beat_t dma_s;
    dac_chan_pkg::dac_beat_t exp_beat;
    logic [3:0]              exp_frame;
    logic                    sync_s;

    for (int i = 0; i < count; i++) begin
      @(posedge dac_div_clk);
      // inputs the DUT took at this edge
      dma_s  = dma_data;
      sync_s = data_sync;
      dma_data  <= random_bits(64);
      data_sync <= 1'(random_bits(1));
      exp_beat  = dac_channel_model::predict_mux(sel_now, sync_s, 64'd0, dma_s, p1, p2);
      exp_frame = dac_channel_model::predict_frame(sel_now, sync_s);
      @(negedge dac_div_clk);
      if (dac_data !== exp_beat) report_mismatch("dac_data", exp_beat, dac_data);
      if (dac_frame !== exp_frame) report_mismatch("dac_frame", 64'(exp_frame), 64'(dac_frame));
      if (dac_enable !== dac_channel_model::predict_enable(sel_now)) begin
        report_mismatch("dac_enable", 64'(dac_channel_model::predict_enable(sel_now)),
                        64'(dac_enable));
      end
    end
  endtask

  task automatic run_dds(input logic fmt);
    logic [15:0]             tone_init;
    logic [15:0]             tone_incr;
    logic [15:0]             tone_scale;
    dac_chan_pkg::dac_beat_t hist [3];
    dac_chan_pkg::dac_beat_t exp_beat;
    logic                    sync_s;
    logic                    started;

    @(posedge dac_div_clk);
    dds_format <= fmt;
    data_sync  <= 1'b0;
    write_reg(dac_chan_pkg::addr_sel, 32'(dac_chan_pkg::sel_dds));
    for (int t = 0; t < 2; t++) begin
      tone_init  = 16'(random_bits(16));
      tone_incr  = 16'(random_bits(16));
      tone_scale = 16'(random_bits(16));
      write_reg(8'(dac_chan_pkg::addr_init_1 + 3 * t), {16'd0, tone_init});
      write_reg(8'(dac_chan_pkg::addr_incr_1 + 3 * t), {16'd0, tone_incr});
      write_reg(8'(dac_chan_pkg::addr_scale_1 + 3 * t), {16'd0, tone_scale});
      dac_channel_model::set_tone(t, tone_init, tone_incr, tone_scale);
    end
    started = 1'b0;
    hist = '{default: '0};
    // three sync cycles cover phase, lookup and scale stages
    for (int i = 0; i < DDS_CYCLES + 4; i++) begin
      @(posedge dac_div_clk);
      sync_s = data_sync;
      data_sync <= (i < 3);
      if (sync_s) started = 1'b1;
      if (started) begin
        dac_channel_model::advance_phases(sync_s);
        exp_beat = dac_channel_model::predict_mux(dac_chan_pkg::sel_dds, sync_s, hist[2],
                                                  64'd0, 16'd0, 16'd0);
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = dac_channel_model::predict_dds(fmt);
        @(negedge dac_div_clk);
        if (dac_data !== exp_beat) report_mismatch("dac_data", exp_beat, dac_data);
        if (dac_frame !== {3'b000, sync_s}) begin
          report_mismatch("dac_frame", {63'd0, sync_s}, 64'(dac_frame));
        end
        if (dac_enable !== 1'b0) report_mismatch("dac_enable", 64'd0, 64'(dac_enable));
      end
    end
  endtask

  // ************************************************************************
  // test sequence

  initial begin
    reset      <= 1'b1;
    wr_strobe  <= 1'b0;
    wr_addr    <= '0;
    wr_data    <= '0;
    rd_strobe  <= 1'b0;
    rd_addr    <= '0;
    data_sync  <= 1'b0;
    dds_format <= 1'b0;
    dma_data   <= '0;
    repeat (4) @(posedge dac_div_clk);
    reset <= 1'b0;

    start_errors = errors;
    @(negedge dac_div_clk);
    if (dac_enable !== 1'b0) report_mismatch("dac_enable", 64'd0, 64'(dac_enable));
    if (dac_frame !== 4'd0) report_mismatch("dac_frame", 64'd0, 64'(dac_frame));
    if (dac_data !== 64'd0) report_mismatch("dac_data", 64'd0, dac_data);
    if (wr_ack !== 1'b0) report_mismatch("wr_ack", 64'd0, 64'(wr_ack));
    if (rd_ack !== 1'b0) report_mismatch("rd_ack", 64'd0, 64'(rd_ack));
    read_check(dac_chan_pkg::addr_sel, 32'd0);
    finish_test("reset state");

    start_errors = errors;
    for (int a = 0; a < 10; a++) begin
      written[a] = 32'(random_bits(32));
      write_reg(REG_ADDRS[a], written[a]);
    end
    for (int a = 0; a < 10; a++) begin
      read_check(REG_ADDRS[a], expected_read(a));
    end
    // unmapped address
    read_check(8'h20, 32'd0);
    finish_test("register access");

    start_errors = errors;
    write_reg(dac_chan_pkg::addr_sel, 32'(dac_chan_pkg::sel_dma));
    mux_cycles(dac_chan_pkg::sel_dma, 16'd0, 16'd0, MUX_CYCLES);
    finish_test("dma path");

    start_errors = errors;
    pat_a = 16'(random_bits(16));
    pat_b = 16'(random_bits(16));
    write_reg(dac_chan_pkg::addr_pat_1, {16'd0, pat_a});
    write_reg(dac_chan_pkg::addr_pat_2, {16'd0, pat_b});
    write_reg(dac_chan_pkg::addr_sel, 32'(dac_chan_pkg::sel_pattern_frame));
    mux_cycles(dac_chan_pkg::sel_pattern_frame, pat_a, pat_b, MUX_CYCLES);
    write_reg(dac_chan_pkg::addr_sel, 32'(dac_chan_pkg::sel_pattern));
    mux_cycles(dac_chan_pkg::sel_pattern, pat_a, pat_b, MUX_CYCLES);
    finish_test("pattern modes");

    start_errors = errors;
    run_dds(1'b0);
    finish_test("dds two's complement");
    start_errors = errors;
    run_dds(1'b1);
    finish_test("dds offset binary");

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/dac_chan_pkg.sv
source/dac_chan_regs.sv
source/dds_phase_accum.sv
source/dds_tone_gen.sv
source/dac_data_mux.sv
source/dac_channel_top.sv
bench/dac_channel_model.sv
bench/dac_channel_tb.sv

// ==== Makefile ====
# Verilator simulation of the dac transmit channel

VERILATOR ?= verilator
TOP       ?= dac_channel_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
